//--- sources.f
+incdir+design
+incdir+dv
design/bmuPkg.sv
design/decodeStageReg.sv
design/bmuDecodeTable.sv
design/executeCtrlReg.sv
design/bmuCtrl.sv
dv/bmuCtrlTb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= bmuCtrlTb
RTL_TOP   ?= bmuCtrl
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP) $(VFLAGS)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) design/*.sv design/*.svh dv/*.sv dv/*.svh
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR) $(VFLAGS)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/bmuCtrlModel.svh
`ifndef BMU_CTRL_MODEL_SVH
`define BMU_CTRL_MODEL_SVH

////////////////////
// reference decoder

// one recognized row, every legal op writes rd and owns the ALU select
function automatic bmuPkg::bmuControlsT rowWord(input bmuPkg::aluSelectT sel,
    input bmuPkg::bSelectT unit, input bmuPkg::zbbSelectT zsel, input logic srcB,
    input logic word, input logic sub, input logic rot, input logic mask, input logic pre);
  bmuPkg::bmuControlsT c;
  c = '0;
  c.aluSelect = sel;
  c.bSelect   = unit;
  c.zbbSelect = zsel;
  c.regWrite  = 1'b1;
  c.aluSrcB   = srcB;
  c.w64       = word;
  c.aluOp     = 1'b1;
  c.subArith  = sub;
  c.rotate    = rot;
  c.mask      = mask;
  c.preShift  = pre;
  return c;
endfunction

function automatic bmuPkg::bmuControlsT refDecode(input logic [31:0] instr);
  bmuPkg::bmuControlsT c;
  bmuPkg::opcodeT op;
  bmuPkg::funct3T f3;
  bmuPkg::funct7T f7;
  bmuPkg::regIdxT rs2;
  logic isShift;   // base shift pattern, shared by all four opcodes
  logic unaryCnt;  // clz/ctz/cpop rs2 codes
  op  = instr[6:0];
  f3  = instr[14:12];
  rs2 = instr[24:20];
  f7  = instr[31:25];
  isShift  = !f7[6] && (f7[4:1] == 4'b0000) && (f3[1:0] == 2'b01);
  unaryCnt = (rs2[4:2] == 3'b000) && (rs2[1:0] != 2'b11);
  c = '0;
  c.illegal = 1'b1;
  case (op)
    `OP_REG: begin
      if (isShift) c = rowWord(3'd1, 4'd0, 4'd0, 0, 0, 0, 0, 0, 0);
      else if (f7 == 7'b0010000 && f3 inside {3'b010, 3'b100, 3'b110})
        c = rowWord(3'd0, 4'd1, 4'd0, 0, 0, 0, 0, 0, 1);  // shNadd
      else if (f7 == 7'b0000101 && f3[2])
        c = rowWord(3'd0, 4'd2, f3[1] ? 4'd7 : 4'd3, 0, 0, 1, 0, 0, 0);  // min/max
      else if (f7 == 7'b0100100 && f3 == 3'b001) c = rowWord(3'd7, 4'd1, 4'd0, 0, 0, 1, 0, 1, 0);
      else if (f7 == 7'b0100100 && f3 == 3'b101) c = rowWord(3'd5, 4'd1, 4'd0, 0, 0, 1, 0, 1, 0);
      else if (f7 == 7'b0110100 && f3 == 3'b001) c = rowWord(3'd4, 4'd1, 4'd0, 0, 0, 0, 0, 1, 0);
      else if (f7 == 7'b0010100 && f3 == 3'b001) c = rowWord(3'd6, 4'd1, 4'd0, 0, 0, 0, 0, 1, 0);
      else if (f7 == 7'b0110000 && f3[1:0] == 2'b01)
        c = rowWord(3'd1, 4'd1, 4'd7, 0, 0, 0, 1, 0, 0);  // rol, ror
      else if (f7 == 7'b0100000 && f3 inside {3'b100, 3'b110, 3'b111})
        c = rowWord(f3, 4'd1, 4'd7, 0, 0, 1, 0, 0, 0);   // xnor, orn, andn
    end
    `OP_IMM: begin
      if (isShift) c = rowWord(3'd1, 4'd0, 4'd0, 1, 0, 0, 0, 0, 0);
      else if (f7 == 7'b0110000 && f3 == 3'b001 && rs2[4:1] == 4'b0010)
        c = rowWord(3'd0, 4'd2, 4'd1, 1, 0, 0, 0, 0, 0);  // sext
      else if (f7 == 7'b0110000 && f3 == 3'b001 && unaryCnt)
        c = rowWord(3'd0, 4'd2, 4'd0, 1, 0, 0, 0, 0, 0);
      else if (f7 == 7'b0010100 && f3 == 3'b101 && rs2 == 5'd7)
        c = rowWord(3'd0, 4'd2, 4'd2, 1, 0, 0, 0, 0, 0);  // orc.b
      else if (f7[6:1] == 6'b010010 && f3 == 3'b001) c = rowWord(3'd7, 4'd1, 4'd0, 1, 0, 1, 0, 1, 0);
      else if (f7[6:1] == 6'b010010 && f3 == 3'b101) c = rowWord(3'd5, 4'd1, 4'd0, 1, 0, 1, 0, 1, 0);
      else if (f7[6:1] == 6'b011010 && f3 == 3'b001) c = rowWord(3'd4, 4'd1, 4'd0, 1, 0, 0, 0, 1, 0);
      else if (f7[6:1] == 6'b001010 && f3 == 3'b001) c = rowWord(3'd6, 4'd1, 4'd0, 1, 0, 0, 0, 1, 0);
      else if (f7 == 7'b0110101 && f3 == 3'b101 && rs2 == 5'd24)
        c = rowWord(3'd0, 4'd2, 4'd2, 1, 0, 0, 0, 0, 0);  // rev8
      else if (f7[6:1] == 6'b011000 && f3 == 3'b101)
        c = rowWord(3'd1, 4'd0, 4'd7, 1, 0, 0, 1, 0, 0);  // rori
    end
    `OP_REG32: begin
      if (isShift) c = rowWord(3'd1, 4'd0, 4'd0, 0, 1, 0, 0, 0, 0);
      else if (f7 == 7'b0010000 && f3 inside {3'b010, 3'b100, 3'b110})
        c = rowWord(3'd0, 4'd1, 4'd0, 0, 1, 0, 0, 0, 1);  // shNadd.uw
      else if (f7 == 7'b0000100 && f3 == 3'b000) c = rowWord(3'd0, 4'd1, 4'd0, 0, 1, 0, 0, 0, 0);
      else if (f7 == 7'b0000100 && f3 == 3'b100)
        c = rowWord(3'd0, 4'd2, 4'd1, 0, 0, 0, 0, 0, 0);  // zext.h, not a word op
      else if (f7 == 7'b0110000 && f3[1:0] == 2'b01)
        c = rowWord(3'd1, 4'd0, 4'd7, 0, 1, 0, 1, 0, 0);
    end
    `OP_IMM32: begin
      if (isShift) c = rowWord(3'd1, 4'd0, 4'd0, 1, 1, 0, 0, 0, 0);
      else if (f7[6:1] == 6'b000010 && f3 == 3'b001)
        c = rowWord(3'd1, 4'd1, 4'd0, 1, 1, 0, 0, 0, 0);  // slli.uw
      else if (f7 == 7'b0110000 && f3 == 3'b001 && unaryCnt)
        c = rowWord(3'd0, 4'd2, 4'd0, 1, 1, 0, 0, 0, 0);
      else if (f7 == 7'b0110000 && f3 == 3'b101)
        c = rowWord(3'd1, 4'd0, 4'd7, 1, 1, 0, 1, 0, 0);  // roriw
    end
    default: ;
  endcase
  return c;
endfunction

////////////////////
// shadow D and E registers

logic [31:0]         expInstrD;
logic                expAluOpD;
bmuPkg::bSelectT     expBSelE;
bmuPkg::zbbSelectT   expZbbE;
logic                expRegWriteE;
bmuPkg::bAluControlT expCtlE;
logic                expActiveE;

task automatic modelClock(input logic [31:0] instr, input logic aluOp, input logic stD,
    input logic flD, input logic stE, input logic flE);
  bmuPkg::bmuControlsT c;
  c = refDecode(expInstrD);  // E takes the old D contents
  if (!stE) begin
    expBSelE     = flE ? '0 : c.bSelect;
    expZbbE      = flE ? '0 : c.zbbSelect;
    expRegWriteE = flE ? 1'b0 : c.regWrite;
    expCtlE      = flE ? '0 : {c.rotate, c.mask, c.preShift};
    expActiveE   = flE ? 1'b0 : !c.illegal;
  end
  if (!stD) begin
    expInstrD = flD ? '0 : instr;
    expAluOpD = flD ? 1'b0 : aluOp;
  end
endtask

`endif

//--- dv/bmuCtrlTb.sv
`timescale 1ns/100ps
`include "bmuCtrl_config.svh"

module bmuCtrlTb;

  logic clk;
  logic arstN;
  logic stallD, flushD, stallE, flushE;
  logic [`BMU_INSTR_W-1:0] instrF;
  logic aluOpF;
  bmuPkg::bSelectT bSelectD, bSelectE;
  bmuPkg::zbbSelectT zbbSelectD, zbbSelectE;
  logic bRegWriteD, bAluSrcBD, bW64D, bSubArithD, illegalBitmanipD;
  bmuPkg::aluSelectT aluSelectD;
  logic bRegWriteE, bmuActiveE;
  bmuPkg::bAluControlT bAluControlE;

  int decodeErrors, selectErrors, executeErrors, timeoutErrors;
  logic [15:0] lfsrState;  // stimulus generator

  // kept encodings with zero register fields
  localparam logic [31:0] keptTpl [0:51] = '{
    32'h20002033, 32'h20004033, 32'h20006033, 32'h2000203B, 32'h2000403B, 32'h2000603B,
    32'h0800003B, 32'h0800101B, 32'h60401013, 32'h60501013, 32'h60001013, 32'h60101013,
    32'h60201013, 32'h6000101B, 32'h6010101B, 32'h6020101B, 32'h28705013, 32'h0A006033,
    32'h0A007033, 32'h0A004033, 32'h0A005033, 32'h0800403B, 32'h40007033, 32'h40006033,
    32'h40004033, 32'h60001033, 32'h60005033, 32'h6000103B, 32'h6000503B, 32'h60005013,
    32'h6000501B, 32'h6B805013, 32'h48001033, 32'h48005033, 32'h68001033, 32'h28001033,
    32'h48001013, 32'h48005013, 32'h68001013, 32'h28001013, 32'h00001033, 32'h00005033,
    32'h40005033, 32'h00001013, 32'h00005013, 32'h40005013, 32'h0000103B, 32'h0000503B,
    32'h4000503B, 32'h0000101B, 32'h0000501B, 32'h4000501B};
  // 0 unary, 1 rs2 or 5-bit shamt, 2 6-bit shamt
  localparam logic [1:0] keptKind [0:51] = '{
    1, 1, 1, 1, 1, 1, 1, 2, 0, 0, 0, 0, 0,
    0, 0, 0, 0, 1, 1, 1, 1, 0, 1, 1, 1, 1,
    1, 1, 1, 2, 1, 0, 1, 1, 1, 1, 2, 2, 2,
    2, 1, 1, 1, 2, 2, 2, 1, 1, 1, 1, 1, 1};

  `include "bmuCtrlModel.svh"

  bmuCtrl dut0 (
    .clk(clk), .arstN(arstN), .stallD(stallD), .flushD(flushD), .instrF(instrF),
    .aluOpF(aluOpF), .stallE(stallE), .flushE(flushE), .bSelectD(bSelectD),
    .zbbSelectD(zbbSelectD), .bRegWriteD(bRegWriteD), .bAluSrcBD(bAluSrcBD),
    .bW64D(bW64D), .bSubArithD(bSubArithD), .illegalBitmanipD(illegalBitmanipD),
    .aluSelectD(aluSelectD), .bSelectE(bSelectE), .zbbSelectE(zbbSelectE),
    .bRegWriteE(bRegWriteE), .bAluControlE(bAluControlE), .bmuActiveE(bmuActiveE)
  );

  always #10 clk = ~clk;  // 20 ns period

  ////////////////////
  // random source

  function automatic logic lfsrStep();
    logic out;
    out = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (out) lfsrState = lfsrState ^ 16'hB400;  // galois taps
    return out;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], lfsrStep()};
    return r;
  endfunction

  function automatic logic [31:0] pickInstr();
    int idx;
    logic [31:0] w;
    if (randBits(1)) return randBits(32);  // mostly illegal noise
    idx = randBits(6) % 52;
    w = keptTpl[idx] | (randBits(32) & 32'h000F8F80);  // rd, rs1
    if (keptKind[idx] != 2'd0) w = w | (randBits(32) & 32'h01F00000);
    if (keptKind[idx] == 2'd2) w = w | (randBits(32) & 32'h02000000);  // shamt[5]
    return w;
  endfunction

  ////////////////////
  // compare tasks

  // fields that the Decode outputs expose
  function automatic bmuPkg::bmuControlsT visible(input bmuPkg::bmuControlsT c);
    bmuPkg::bmuControlsT v;
    v = c;
    v.aluSelect = '0;
    v.aluOp = 1'b0;
    {v.rotate, v.mask, v.preShift} = 3'b000;
    return v;
  endfunction

  task automatic checkDecode(input bmuPkg::bmuControlsT exp, input bmuPkg::bmuControlsT got);
    if (visible(exp) !== visible(got)) begin
      decodeErrors++;
      $display("[ERROR] %0t: decode word exp %h got %h instr %h", $time,
               visible(exp), visible(got), expInstrD);
    end
  endtask

  task automatic checkAluSelect(input bmuPkg::aluSelectT exp, input bmuPkg::aluSelectT got);
    if (exp !== got) begin
      selectErrors++;
      $display("[ERROR] %0t: aluSelectD exp %0d got %0d", $time, exp, got);
    end
  endtask

  task automatic checkExecute(input bmuPkg::bSelectT expB, input bmuPkg::zbbSelectT expZ,
      input bmuPkg::bAluControlT expC, input logic expRw, input logic expAct);
    if ({expB, expZ, expC, expRw, expAct} !==
        {bSelectE, zbbSelectE, bAluControlE, bRegWriteE, bmuActiveE}) begin
      executeErrors++;
      $display("[ERROR] %0t: execute exp b%0d z%0d c%b rw%b act%b got b%0d z%0d c%b rw%b act%b",
               $time, expB, expZ, expC, expRw, expAct,
               bSelectE, zbbSelectE, bAluControlE, bRegWriteE, bmuActiveE);
    end
  endtask

  task automatic compareAll();
    bmuPkg::bmuControlsT exp, got;
    bmuPkg::aluSelectT expSel;
    exp = refDecode(expInstrD);
    got = '0;
    got.bSelect = bSelectD;
    got.zbbSelect = zbbSelectD;
    got.regWrite = bRegWriteD;
    got.aluSrcB = bAluSrcBD;
    got.w64 = bW64D;
    got.subArith = bSubArithD;
    got.illegal = illegalBitmanipD;
    checkDecode(exp, got);
    expSel = exp.aluOp ? exp.aluSelect : (expAluOpD ? expInstrD[14:12] : 3'd0);
    checkAluSelect(expSel, aluSelectD);
    checkExecute(expBSelE, expZbbE, expCtlE, expRegWriteE, expActiveE);
  endtask

  ////////////////////
  // main sequence

  initial begin
    int waitCnt;
    clk = 0;
    arstN = 0;
    {stallD, flushD, stallE, flushE, aluOpF} = '0;
    instrF = '0;
    lfsrState = 16'd88;
    {decodeErrors, selectErrors, executeErrors, timeoutErrors} = '0;
    {expInstrD, expAluOpD, expBSelE, expZbbE, expRegWriteE, expCtlE, expActiveE} = '0;
    repeat (10) @(posedge clk);
    #2 arstN = 1;
    waitCnt = 0;
    while (!(illegalBitmanipD && !bmuActiveE) && waitCnt < 20) begin  // reset state
      @(posedge clk);
      #2;
      waitCnt++;
    end
    if (waitCnt >= 20) begin
      timeoutErrors++;
      $display("timed out waiting for the reset state on the outputs");
    end
    compareAll();  // idle state before any capture
    // one capture per edge, inputs held across it
    for (int n = 0; n < 4000; n++) begin
      instrF = pickInstr();
      aluOpF = (randBits(2) == 0);
      stallD = (randBits(3) == 0);
      flushD = (randBits(4) == 0);
      stallE = (randBits(3) == 0);
      flushE = (randBits(4) == 0);
      @(posedge clk);
      modelClock(instrF, aluOpF, stallD, flushD, stallE, flushE);
      #1 compareAll();
      #1;  // next drive point
    end
    // drain both stages with bubbles
    {stallD, flushD, stallE, flushE, aluOpF} = '0;
    instrF = '0;
    waitCnt = 0;
    while ((bmuActiveE || !illegalBitmanipD) && waitCnt < 8) begin
      @(posedge clk);
      modelClock(instrF, aluOpF, stallD, flushD, stallE, flushE);
      #1 compareAll();
      waitCnt++;
    end
    if (waitCnt >= 8) begin
      timeoutErrors++;
      $display("timed out waiting for the pipeline to drain");
    end
    $display("errors: decode %0d select %0d execute %0d timeout %0d",
             decodeErrors, selectErrors, executeErrors, timeoutErrors);
    if (decodeErrors + selectErrors + executeErrors + timeoutErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- design/bmuCtrl.sv
`timescale 1ns/100ps
`include "bmuCtrl_config.svh"

module bmuCtrl (
  input  logic                    clk,
  input  logic                    arstN,
  // Decode stage
  input  logic                    stallD,            // hold D
  input  logic                    flushD,            // bubble into D
  input  logic [`BMU_INSTR_W-1:0] instrF,            // fetched instruction
  input  logic                    aluOpF,            // regular ALU op
  input  logic                    stallE,            // hold E
  input  logic                    flushE,            // bubble into E
  output bmuPkg::bSelectT         bSelectD,
  output bmuPkg::zbbSelectT       zbbSelectD,
  output logic                    bRegWriteD,        // R-type bit-manip
  output logic                    bAluSrcBD,         // immediate form
  output logic                    bW64D,             // word form
  output logic                    bSubArithD,        // inverted operand B
  output logic                    illegalBitmanipD,  // unrecognized op
  output bmuPkg::aluSelectT       aluSelectD,
  // Execute stage
  output bmuPkg::bSelectT         bSelectE,
  output bmuPkg::zbbSelectT       zbbSelectE,
  output logic                    bRegWriteE,
  output bmuPkg::bAluControlT     bAluControlE,      // {rotate, mask, preShift}
  output logic                    bmuActiveE
);

  bmuPkg::opcodeT      opD;
  bmuPkg::funct3T      funct3D;
  bmuPkg::funct7T      funct7D;
  bmuPkg::regIdxT      rs2D;
  logic                aluOpD;   // registered ALU flag
  bmuPkg::bmuControlsT ctrlD;    // decoded control word

  ////////////////////
  // input side

  decodeStageReg instrReg0 (
    .clk     (clk),
    .arstN   (arstN),
    .stallD  (stallD),
    .flushD  (flushD),
    .instrF  (instrF),
    .aluOpF  (aluOpF),
    .opD     (opD),
    .funct3D (funct3D),
    .funct7D (funct7D),
    .rs2D    (rs2D),
    .aluOpD  (aluOpD)
  );

  ////////////////////
  // decode

  bmuDecodeTable decTable0 (
    .opD     (opD),
    .funct3D (funct3D),
    .funct7D (funct7D),
    .rs2D    (rs2D),
    .ctrlD   (ctrlD)
  );

  // Decode-stage fan out
  assign bSelectD         = ctrlD.bSelect;
  assign zbbSelectD       = ctrlD.zbbSelect;
  assign bRegWriteD       = ctrlD.regWrite;
  assign bAluSrcBD        = ctrlD.aluSrcB;
  assign bW64D            = ctrlD.w64;
  assign bSubArithD       = ctrlD.subArith;
  assign illegalBitmanipD = ctrlD.illegal;

  ////////////////////
  // output side

  executeCtrlReg exReg0 (
    .clk          (clk),
    .arstN        (arstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .ctrlD        (ctrlD),
    .funct3D      (funct3D),
    .aluOpD       (aluOpD),
    .aluSelectD   (aluSelectD),
    .bSelectE     (bSelectE),
    .zbbSelectE   (zbbSelectE),
    .bRegWriteE   (bRegWriteE),
    .bAluControlE (bAluControlE),
    .bmuActiveE   (bmuActiveE)
  );

endmodule

//--- design/executeCtrlReg.sv
`timescale 1ns/100ps

module executeCtrlReg (
  input  logic                clk,
  input  logic                arstN,
  input  logic                stallE,        // hold the E register
  input  logic                flushE,        // bubble into E
  input  bmuPkg::bmuControlsT ctrlD,         // decoded controls
  input  bmuPkg::funct3T      funct3D,       // base ALU op
  input  logic                aluOpD,        // regular ALU op in D
  output bmuPkg::aluSelectT   aluSelectD,
  output bmuPkg::bSelectT     bSelectE,
  output bmuPkg::zbbSelectT   zbbSelectE,
  output logic                bRegWriteE,
  output bmuPkg::bAluControlT bAluControlE,  // {rotate, mask, preShift}
  output logic                bmuActiveE     // bit-manip op in Execute
);

  bmuPkg::bAluControlT bAluControlD;  // packed shifter controls

  ////////////////////
  // ALU select

  // table select for bit-manip, funct3 for base ALU ops, else add
  always_comb begin
    if (ctrlD.aluOp) begin
      aluSelectD = ctrlD.aluSelect;
    end else if (aluOpD) begin
      aluSelectD = funct3D;
    end else begin
      aluSelectD = '0;  // add for loads, stores, branches
    end
  end

  assign bAluControlD = {ctrlD.rotate, ctrlD.mask, ctrlD.preShift};

  ////////////////////
  // D -> E register

  // 13 bits, stall wins over flush
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {bSelectE, zbbSelectE, bRegWriteE, bAluControlE, bmuActiveE} <= '0;
    end else if (!stallE) begin
      if (flushE) begin
        {bSelectE, zbbSelectE, bRegWriteE, bAluControlE, bmuActiveE} <= '0;  // bubble
      end else begin
        bSelectE     <= ctrlD.bSelect;
        zbbSelectE   <= ctrlD.zbbSelect;
        bRegWriteE   <= ctrlD.regWrite;
        bAluControlE <= bAluControlD;
        bmuActiveE   <= ~ctrlD.illegal;  // any recognized bit-manip op
      end
    end
  end

  // a flushed Execute slot never reports an active bit-manip op
  flushKillsActive: assert property (
    @(posedge clk) disable iff (!arstN)
    (flushE && !stallE) |=> !bmuActiveE
  ) else $error("bmuActiveE set after an unstalled flush");

endmodule

//--- design/bmuDecodeTable.sv
`timescale 1ns/100ps
`include "bmuCtrl_config.svh"

module bmuDecodeTable (
  input  bmuPkg::opcodeT      opD,
  input  bmuPkg::funct3T      funct3D,
  input  bmuPkg::funct7T      funct7D,
  input  bmuPkg::regIdxT      rs2D,     // op extension for unary rows
  output bmuPkg::bmuControlsT ctrlD     // decoded control word
);

  logic [`BMU_CTRL_W-1:0] cw;  // raw control word

  ////////////////////
  // main decode

  // field order
  // aluSelect_bSelect_zbbSelect_regWrite_aluSrcB_w64_aluOp_subArith_rotate_mask_preShift_illegal
  // later rows override earlier ones
  always_comb begin
    cw = 20'b000_0000_0000_0_0_0_0_0_0_0_0_1;  // default illegal

    if (`ZBA_EN) begin
      casez ({opD, funct7D, funct3D})
        {`OP_REG, 7'b0010000, 3'b010}: cw = 20'b000_0001_0000_1_0_0_1_0_0_0_1_0;  // sh1add
        {`OP_REG, 7'b0010000, 3'b100}: cw = 20'b000_0001_0000_1_0_0_1_0_0_0_1_0;  // sh2add
        {`OP_REG, 7'b0010000, 3'b110}: cw = 20'b000_0001_0000_1_0_0_1_0_0_0_1_0;  // sh3add
        {`OP_REG32, 7'b0010000, 3'b010}: cw = 20'b000_0001_0000_1_0_1_1_0_0_0_1_0;  // sh1add.uw
        {`OP_REG32, 7'b0010000, 3'b100}: cw = 20'b000_0001_0000_1_0_1_1_0_0_0_1_0;  // sh2add.uw
        {`OP_REG32, 7'b0010000, 3'b110}: cw = 20'b000_0001_0000_1_0_1_1_0_0_0_1_0;  // sh3add.uw
        {`OP_REG32, 7'b0000100, 3'b000}: cw = 20'b000_0001_0000_1_0_1_1_0_0_0_0_0;  // add.uw
        {`OP_IMM32, 7'b000010?, 3'b001}: cw = 20'b001_0001_0000_1_1_1_1_0_0_0_0_0;  // slli.uw
        default: ;
      endcase
    end

    if (`ZBB_EN) begin
      casez ({opD, funct7D, funct3D})
        {`OP_IMM, 7'b0110000, 3'b001}:
          if (rs2D[4:1] == 4'b0010)
            cw = 20'b000_0010_0001_1_1_0_1_0_0_0_0_0;  // sext.b, sext.h
          else if ((rs2D[4:2] == 3'b000) && !(rs2D[1] && rs2D[0]))
            cw = 20'b000_0010_0000_1_1_0_1_0_0_0_0_0;  // clz, ctz, cpop
        {`OP_IMM, 7'b0010100, 3'b101}:
          if (rs2D == 5'b00111)
            cw = 20'b000_0010_0010_1_1_0_1_0_0_0_0_0;  // orc.b
        {`OP_REG, 7'b0000101, 3'b110}: cw = 20'b000_0010_0111_1_0_0_1_1_0_0_0_0;  // max
        {`OP_REG, 7'b0000101, 3'b111}: cw = 20'b000_0010_0111_1_0_0_1_1_0_0_0_0;  // maxu
        {`OP_REG, 7'b0000101, 3'b100}: cw = 20'b000_0010_0011_1_0_0_1_1_0_0_0_0;  // min
        {`OP_REG, 7'b0000101, 3'b101}: cw = 20'b000_0010_0011_1_0_0_1_1_0_0_0_0;  // minu
        {`OP_REG32, 7'b0000100, 3'b100}: cw = 20'b000_0010_0001_1_0_0_1_0_0_0_0_0;  // zext.h
        {`OP_IMM32, 7'b0110000, 3'b001}:
          if ((rs2D[4:2] == 3'b000) && !(rs2D[1] && rs2D[0]))
            cw = 20'b000_0010_0000_1_1_1_1_0_0_0_0_0;  // clzw, ctzw, cpopw
        default: ;
      endcase
    end

    if (`ZBS_EN) begin
      casez ({opD, funct7D, funct3D})
        {`OP_REG, 7'b0100100, 3'b001}: cw = 20'b111_0001_0000_1_0_0_1_1_0_1_0_0;  // bclr
        {`OP_REG, 7'b0100100, 3'b101}: cw = 20'b101_0001_0000_1_0_0_1_1_0_1_0_0;  // bext
        {`OP_REG, 7'b0110100, 3'b001}: cw = 20'b100_0001_0000_1_0_0_1_0_0_1_0_0;  // binv
        {`OP_REG, 7'b0010100, 3'b001}: cw = 20'b110_0001_0000_1_0_0_1_0_0_1_0_0;  // bset
        // immediate forms, funct7[0] is shamt[5]
        {`OP_IMM, 7'b010010?, 3'b001}: cw = 20'b111_0001_0000_1_1_0_1_1_0_1_0_0;  // bclri
        {`OP_IMM, 7'b010010?, 3'b101}: cw = 20'b101_0001_0000_1_1_0_1_1_0_1_0_0;  // bexti
        {`OP_IMM, 7'b011010?, 3'b001}: cw = 20'b100_0001_0000_1_1_0_1_0_0_1_0_0;  // binvi
        {`OP_IMM, 7'b001010?, 3'b001}: cw = 20'b110_0001_0000_1_1_0_1_0_0_1_0_0;  // bseti
        default: ;
      endcase
    end

    // base shifts go through the bit-manip shifter
    if (`ZBB_EN || `ZBS_EN) begin
      casez ({opD, funct7D, funct3D})
        {`OP_REG, 7'b0?0000?, 3'b?01}: cw = 20'b001_0000_0000_1_0_0_1_0_0_0_0_0;  // sll, srl, sra
        {`OP_IMM, 7'b0?0000?, 3'b?01}: cw = 20'b001_0000_0000_1_1_0_1_0_0_0_0_0;  // slli, srli, srai
        {`OP_REG32, 7'b0?0000?, 3'b?01}: cw = 20'b001_0000_0000_1_0_1_1_0_0_0_0_0;  // sllw..sraw
        {`OP_IMM32, 7'b0?0000?, 3'b?01}: cw = 20'b001_0000_0000_1_1_1_1_0_0_0_0_0;  // slliw..
        default: ;
      endcase
    end

    // rotates and inverted logic
    if (`ZBB_EN) begin
      casez ({opD, funct7D, funct3D})
        {`OP_REG, 7'b0110000, 3'b001}: cw = 20'b001_0001_0111_1_0_0_1_0_1_0_0_0;  // rol
        {`OP_REG, 7'b0110000, 3'b101}: cw = 20'b001_0001_0111_1_0_0_1_0_1_0_0_0;  // ror
        {`OP_REG, 7'b0100000, 3'b111}: cw = 20'b111_0001_0111_1_0_0_1_1_0_0_0_0;  // andn
        {`OP_REG, 7'b0100000, 3'b110}: cw = 20'b110_0001_0111_1_0_0_1_1_0_0_0_0;  // orn
        {`OP_REG, 7'b0100000, 3'b100}: cw = 20'b100_0001_0111_1_0_0_1_1_0_0_0_0;  // xnor
        {`OP_IMM, 7'b011010?, 3'b101}:
          if (funct7D[0] && (rs2D == 5'b11000))
            cw = 20'b000_0010_0010_1_1_0_1_0_0_0_0_0;  // rev8, 64-bit encoding
        {`OP_REG32, 7'b0110000, 3'b001}: cw = 20'b001_0000_0111_1_0_1_1_0_1_0_0_0;  // rolw
        {`OP_REG32, 7'b0110000, 3'b101}: cw = 20'b001_0000_0111_1_0_1_1_0_1_0_0_0;  // rorw
        {`OP_IMM, 7'b011000?, 3'b101}: cw = 20'b001_0000_0111_1_1_0_1_0_1_0_0_0;  // rori
        {`OP_IMM32, 7'b0110000, 3'b101}: cw = 20'b001_0000_0111_1_1_1_1_0_1_0_0_0;  // roriw
        default: ;
      endcase
    end
  end

  assign ctrlD = cw;  // unpack into named fields

  ////////////////////
  // table consistency

  // an illegal decode carries no stray controls into the pipeline
  always_comb begin
    assert final (!ctrlD.illegal ||
                  ((ctrlD.bSelect == bmuPkg::bSelNone) && (cw[`BMU_CTRL_W-1:1] == '0)))
      else $error("illegal decode with nonzero control fields");
  end

endmodule

//--- design/decodeStageReg.sv
`timescale 1ns/100ps
`include "bmuCtrl_config.svh"

module decodeStageReg (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    stallD,   // hold the D register
  input  logic                    flushD,   // bubble into D
  input  logic [`BMU_INSTR_W-1:0] instrF,   // fetched instruction
  input  logic                    aluOpF,   // regular ALU op from main decoder
  output bmuPkg::opcodeT          opD,
  output bmuPkg::funct3T          funct3D,
  output bmuPkg::funct7T          funct7D,
  output bmuPkg::regIdxT          rs2D,     // rs2 field, also op extension
  output logic                    aluOpD
);

  logic [`BMU_INSTR_W-1:0] instrD;  // instruction in Decode

  ////////////////////
  // F -> D register

  // stall wins over flush, flush loads a zero bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD <= '0;     // zero decodes as illegal
      aluOpD <= 1'b0;
    end else if (!stallD) begin
      if (flushD) begin
        instrD <= '0;   // bubble
        aluOpD <= 1'b0;
      end else begin
        instrD <= instrF;
        aluOpD <= aluOpF;
      end
    end
  end

  ////////////////////
  // field slicing

  assign opD     = instrD[6:0];    // major opcode
  assign funct3D = instrD[14:12];  // minor op
  assign rs2D    = instrD[24:20];  // rs2 / shamt low bits
  assign funct7D = instrD[31:25];  // upper op, shamt[5] in bit 0

  // a stalled edge must not move the instruction on to a new decode
  holdOnStall: assert property (
    @(posedge clk) disable iff (!arstN)
    stallD |=> $stable(opD)
  ) else $error("opD changed across a stalled edge");

endmodule

//--- design/bmuPkg.sv
package bmuPkg;

  ////////////////////
  // instruction fields

  typedef logic [6:0] opcodeT;   // major opcode, instr[6:0]
  typedef logic [2:0] funct3T;   // minor op, instr[14:12]
  typedef logic [6:0] funct7T;   // upper op, instr[31:25]
  typedef logic [4:0] regIdxT;   // register index, rs2 doubles as op extension

  ////////////////////
  // decode outputs

  typedef logic [2:0] aluSelectT;    // ALU result mux select
  typedef logic [3:0] bSelectT;      // bit-manip unit select
  typedef logic [3:0] zbbSelectT;    // Zbb sub-op select
  typedef logic [2:0] bAluControlT;  // {rotate, mask, preShift}

  // unit-select codes
  localparam bSelectT bSelNone   = 4'd0;  // plain ALU op
  localparam bSelectT bSelBitOps = 4'd1;  // Zba, Zbs, rotate and shift path
  localparam bSelectT bSelZbb    = 4'd2;  // count, extend, min/max, orc.b, rev8

  // full control word, msb first
  typedef struct packed {
    aluSelectT aluSelect;  // ALU select for bit-manip ops
    bSelectT   bSelect;    // unit select
    zbbSelectT zbbSelect;  // Zbb mux select
    logic      regWrite;   // writes rd
    logic      aluSrcB;    // immediate on operand B
    logic      w64;        // word form
    logic      aluOp;      // table owns the ALU select
    logic      subArith;   // invert operand B
    logic      rotate;     // rotate instead of shift
    logic      mask;       // one-hot mask from rs2
    logic      preShift;   // shNadd pre-shift of rs1
    logic      illegal;    // not a recognized bit-manip op
  } bmuControlsT;

endpackage

//--- design/bmuCtrl_config.svh
`ifndef BMU_CTRL_CONFIG_SVH
`define BMU_CTRL_CONFIG_SVH

////////////////////
// widths

`define BMU_INSTR_W 32  // fetched instruction word
`define BMU_CTRL_W  20  // decoded control word, matches bmuPkg::bmuControlsT

////////////////////
// major opcodes matched by the decode table

`define OP_REG   7'b0110011  // R-type, 64-bit
`define OP_IMM   7'b0010011  // I-type, 64-bit
`define OP_REG32 7'b0111011  // R-type word ops
`define OP_IMM32 7'b0011011  // I-type word ops

////////////////////
// extension enables, 1 keeps the rows in the table

`define ZBA_EN 1'b1  // address generation
`define ZBB_EN 1'b1  // basic bit manipulation
`define ZBS_EN 1'b1  // single-bit ops

`endif
